// File: verilog/mmu_pkg.sv
package mmu_pkg;

    // single-cycle TLB operation strobes
    typedef enum logic [1:0]
    {
        OP_NONE  = 2'd0,
        OP_TLBP  = 2'd1,
        OP_TLBR  = 2'd2,
        OP_TLBWI = 2'd3
    } tlb_op_e;

    // cp0 register select for software access
    typedef enum logic [2:0]
    {
        SEL_INDEX    = 3'd0,
        SEL_ENTRYHI  = 3'd1,
        SEL_PAGEMASK = 3'd2,
        SEL_ENTRYLO0 = 3'd3,
        SEL_ENTRYLO1 = 3'd4
    } cp0_sel_e;

    localparam int PAGE_OFFSET_W = 12;
    localparam int PFN_W         = 20;

    // EntryHi fields
    localparam int VPN2_HI     = 31;
    localparam int VPN2_LO     = 13;
    localparam int ASID_HI     = 7;
    localparam int ASID_LO     = 0;
    // global flag as kept inside the stored EntryHi
    localparam int G_STORE_BIT = 12;

    // EntryLo fields
    localparam int PFN_HI = 25;
    localparam int PFN_LO = 6;
    localparam int C_HI   = 5;
    localparam int C_LO   = 3;
    localparam int D_BIT  = 2;
    localparam int V_BIT  = 1;
    localparam int G_BIT  = 0;

    localparam logic [2:0] CACHE_UNCACHED = 3'd2;

endpackage

// File: verilog/addr_translate.sv
module addr_translate (
    input  logic [31:0] i_vaddr,
    input  logic        i_hit,
    input  logic [31:0] i_entrylo,
    output logic [31:0] o_paddr,
    output logic        o_uncached,
    output logic        o_refill,
    output logic        o_invalid,
    output logic        o_dirty
);

    logic                             unmapped;
    logic [mmu_pkg::PFN_W-1:0]        pfn;
    logic [mmu_pkg::PAGE_OFFSET_W-1:0] offset;
    logic [2:0]                       cache_attr;

    // kseg0 and kseg1 both sit at 3'b10x
    assign unmapped = i_vaddr[31:30] == 2'b10;

    assign pfn        = i_entrylo[mmu_pkg::PFN_HI:mmu_pkg::PFN_LO];
    assign offset     = i_vaddr[mmu_pkg::PAGE_OFFSET_W-1:0];
    assign cache_attr = i_entrylo[mmu_pkg::C_HI:mmu_pkg::C_LO];

    always_comb
    begin
        if (unmapped)
        begin
            o_paddr    = {3'b000, i_vaddr[28:0]};
            // kseg1 only
            o_uncached = i_vaddr[29];
            o_refill   = 1'b0;
            o_invalid  = 1'b0;
            o_dirty    = 1'b0;
        end
        else
        begin
            o_paddr    = {pfn, offset};
            o_uncached = cache_attr == mmu_pkg::CACHE_UNCACHED;
            o_refill   = ~i_hit;
            o_invalid  = i_hit & ~i_entrylo[mmu_pkg::V_BIT];
            o_dirty    = i_hit & i_entrylo[mmu_pkg::D_BIT];
        end
    end

endmodule

// File: verilog/tlb_match.sv
module tlb_match #(
    parameter int TLB_ENTRIES = 16,
    localparam int IDX_W = $clog2(TLB_ENTRIES),
    localparam int FLAT_W = TLB_ENTRIES * 32
) (
    input  logic [31:0]       i_vaddr,
    input  logic [7:0]        i_asid,
    input  logic [FLAT_W-1:0] i_entryhi_flat,
    input  logic [FLAT_W-1:0] i_pagemask_flat,
    input  logic [FLAT_W-1:0] i_entrylo0_flat,
    input  logic [FLAT_W-1:0] i_entrylo1_flat,
    output logic              o_hit,
    output logic [IDX_W-1:0]  o_hit_index,
    output logic [31:0]       o_entrylo
);

    localparam int VPN2_W = mmu_pkg::VPN2_HI - mmu_pkg::VPN2_LO + 1;

    logic [TLB_ENTRIES-1:0] hit_mask;
    logic                   odd;

    assign odd = i_vaddr[mmu_pkg::PAGE_OFFSET_W];

    for (genvar i = 0; i < TLB_ENTRIES; i++)
    begin : g_cmp
        logic [31:0]       ent_hi;
        logic [VPN2_W-1:0] care;
        logic              vpn_eq;
        logic              asid_ok;

        assign ent_hi = i_entryhi_flat[i*32 +: 32];
        // mask bits widen the page, so those vpn bits are ignored
        assign care = ~i_pagemask_flat[i*32+mmu_pkg::VPN2_LO +: VPN2_W];
        assign vpn_eq = ((i_vaddr[mmu_pkg::VPN2_HI:mmu_pkg::VPN2_LO] ^
                          ent_hi[mmu_pkg::VPN2_HI:mmu_pkg::VPN2_LO]) & care) == '0;
        assign asid_ok = ent_hi[mmu_pkg::G_STORE_BIT] ||
                         (ent_hi[mmu_pkg::ASID_HI:mmu_pkg::ASID_LO] == i_asid);
        assign hit_mask[i] = vpn_eq && asid_ok;
    end

    assign o_hit = |hit_mask;

    // one-hot or'ing, multiple hits give a merged result
    always_comb
    begin
        o_hit_index = '0;
        o_entrylo   = '0;
        for (int i = 0; i < TLB_ENTRIES; i++)
        begin
            if (hit_mask[i])
            begin
                o_hit_index = o_hit_index | IDX_W'(i);
                if (odd)
                begin
                    o_entrylo = o_entrylo | i_entrylo1_flat[i*32 +: 32];
                end
                else
                begin
                    o_entrylo = o_entrylo | i_entrylo0_flat[i*32 +: 32];
                end
            end
        end
    end

endmodule

// File: verilog/tlb_entry_array.sv
module tlb_entry_array #(
    parameter int TLB_ENTRIES = 16,
    localparam int IDX_W = $clog2(TLB_ENTRIES),
    localparam int FLAT_W = TLB_ENTRIES * 32
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_we,
    input  logic [IDX_W-1:0]  i_index,
    input  logic [31:0]       i_entryhi,
    input  logic [31:0]       i_pagemask,
    input  logic [31:0]       i_entrylo0,
    input  logic [31:0]       i_entrylo1,
    output logic [31:0]       o_rd_entryhi,
    output logic [31:0]       o_rd_pagemask,
    output logic [31:0]       o_rd_entrylo0,
    output logic [31:0]       o_rd_entrylo1,
    output logic [FLAT_W-1:0] o_entryhi_flat,
    output logic [FLAT_W-1:0] o_pagemask_flat,
    output logic [FLAT_W-1:0] o_entrylo0_flat,
    output logic [FLAT_W-1:0] o_entrylo1_flat
);

    logic [31:0] mem_hi [TLB_ENTRIES];
    logic [31:0] mem_pm [TLB_ENTRIES];
    logic [31:0] mem_lo0 [TLB_ENTRIES];
    logic [31:0] mem_lo1 [TLB_ENTRIES];

    logic [31:0] wr_hi;
    logic [31:0] wr_lo0;
    logic [31:0] wr_lo1;

    // entry is global only if both halves say so
    always_comb
    begin
        wr_hi = '0;
        wr_hi[mmu_pkg::VPN2_HI:mmu_pkg::VPN2_LO] = i_entryhi[mmu_pkg::VPN2_HI:mmu_pkg::VPN2_LO];
        wr_hi[mmu_pkg::ASID_HI:mmu_pkg::ASID_LO] = i_entryhi[mmu_pkg::ASID_HI:mmu_pkg::ASID_LO];
        wr_hi[mmu_pkg::G_STORE_BIT] = i_entrylo0[mmu_pkg::G_BIT] & i_entrylo1[mmu_pkg::G_BIT];
        wr_lo0 = i_entrylo0;
        wr_lo0[mmu_pkg::G_BIT] = 1'b0;
        wr_lo1 = i_entrylo1;
        wr_lo1[mmu_pkg::G_BIT] = 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < TLB_ENTRIES; i++)
            begin
                mem_hi[i]  <= '0;
                mem_pm[i]  <= '0;
                mem_lo0[i] <= '0;
                mem_lo1[i] <= '0;
            end
        end
        else if (i_we)
        begin
            mem_hi[i_index]  <= wr_hi;
            mem_pm[i_index]  <= i_pagemask;
            mem_lo0[i_index] <= wr_lo0;
            mem_lo1[i_index] <= wr_lo1;
        end
    end

    // read-back for TLBR, global flag returned in both G bits
    always_comb
    begin
        o_rd_entryhi = mem_hi[i_index];
        o_rd_entryhi[mmu_pkg::G_STORE_BIT] = 1'b0;
        o_rd_pagemask = mem_pm[i_index];
        o_rd_entrylo0 = mem_lo0[i_index];
        o_rd_entrylo0[mmu_pkg::G_BIT] = mem_hi[i_index][mmu_pkg::G_STORE_BIT];
        o_rd_entrylo1 = mem_lo1[i_index];
        o_rd_entrylo1[mmu_pkg::G_BIT] = mem_hi[i_index][mmu_pkg::G_STORE_BIT];
    end

    for (genvar i = 0; i < TLB_ENTRIES; i++)
    begin : g_flat
        assign o_entryhi_flat[i*32 +: 32]  = mem_hi[i];
        assign o_pagemask_flat[i*32 +: 32] = mem_pm[i];
        assign o_entrylo0_flat[i*32 +: 32] = mem_lo0[i];
        assign o_entrylo1_flat[i*32 +: 32] = mem_lo1[i];
    end

endmodule

// File: verilog/cp0_tlb_regs.sv
module cp0_tlb_regs #(
    parameter int TLB_ENTRIES = 16,
    localparam int IDX_W = $clog2(TLB_ENTRIES)
) (
    input  logic              clk,
    input  logic              rst,
    input  mmu_pkg::tlb_op_e  i_op,
    input  logic              i_cp0_wr_en,
    input  mmu_pkg::cp0_sel_e i_cp0_sel,
    input  logic [31:0]       i_cp0_wr_data,
    output logic [31:0]       o_cp0_rd_data,
    input  logic              i_probe_hit,
    input  logic [IDX_W-1:0]  i_probe_index,
    input  logic [31:0]       i_rd_entryhi,
    input  logic [31:0]       i_rd_pagemask,
    input  logic [31:0]       i_rd_entrylo0,
    input  logic [31:0]       i_rd_entrylo1,
    output logic [IDX_W-1:0]  o_index,
    output logic [31:0]       o_entryhi,
    output logic [31:0]       o_pagemask,
    output logic [31:0]       o_entrylo0,
    output logic [31:0]       o_entrylo1,
    output logic              o_tlb_we
);

    // implemented fields: vpn2+asid, mask 28:13, pfn+flags
    localparam logic [31:0] ENTRYHI_MASK  = 32'hffff_e0ff;
    localparam logic [31:0] PAGEMASK_MASK = 32'h1fff_e000;
    localparam logic [31:0] ENTRYLO_MASK  = 32'h03ff_ffff;

    logic             probe_fail;
    logic [IDX_W-1:0] index_r;
    logic             op_tlbp;
    logic             op_tlbr;
    logic             wr_index;
    logic             wr_entryhi;
    logic             wr_pagemask;
    logic             wr_entrylo0;
    logic             wr_entrylo1;

    assign op_tlbp  = i_op == mmu_pkg::OP_TLBP;
    assign op_tlbr  = i_op == mmu_pkg::OP_TLBR;
    assign o_tlb_we = i_op == mmu_pkg::OP_TLBWI;

    assign wr_index    = i_cp0_wr_en && i_cp0_sel == mmu_pkg::SEL_INDEX;
    assign wr_entryhi  = i_cp0_wr_en && i_cp0_sel == mmu_pkg::SEL_ENTRYHI;
    assign wr_pagemask = i_cp0_wr_en && i_cp0_sel == mmu_pkg::SEL_PAGEMASK;
    assign wr_entrylo0 = i_cp0_wr_en && i_cp0_sel == mmu_pkg::SEL_ENTRYLO0;
    assign wr_entrylo1 = i_cp0_wr_en && i_cp0_sel == mmu_pkg::SEL_ENTRYLO1;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            probe_fail <= 1'b0;
            index_r    <= '0;
            o_entryhi  <= '0;
            o_pagemask <= '0;
            o_entrylo0 <= '0;
            o_entrylo1 <= '0;
        end
        else
        begin
            // on a probe miss the old index bits stay
            if (op_tlbp)
            begin
                probe_fail <= ~i_probe_hit;
                if (i_probe_hit)
                begin
                    index_r <= i_probe_index;
                end
            end
            else if (wr_index)
            begin
                probe_fail <= i_cp0_wr_data[31];
                index_r    <= i_cp0_wr_data[IDX_W-1:0];
            end

            if (op_tlbr)
            begin
                o_entryhi  <= i_rd_entryhi;
                o_pagemask <= i_rd_pagemask;
                o_entrylo0 <= i_rd_entrylo0;
                o_entrylo1 <= i_rd_entrylo1;
            end
            else
            begin
                if (wr_entryhi)
                begin
                    o_entryhi <= i_cp0_wr_data & ENTRYHI_MASK;
                end
                if (wr_pagemask)
                begin
                    o_pagemask <= i_cp0_wr_data & PAGEMASK_MASK;
                end
                if (wr_entrylo0)
                begin
                    o_entrylo0 <= i_cp0_wr_data & ENTRYLO_MASK;
                end
                if (wr_entrylo1)
                begin
                    o_entrylo1 <= i_cp0_wr_data & ENTRYLO_MASK;
                end
            end
        end
    end

    assign o_index = index_r;

    always_comb
    begin
        case (i_cp0_sel)
            mmu_pkg::SEL_INDEX:    o_cp0_rd_data = {probe_fail, {(31-IDX_W){1'b0}}, index_r};
            mmu_pkg::SEL_ENTRYHI:  o_cp0_rd_data = o_entryhi;
            mmu_pkg::SEL_PAGEMASK: o_cp0_rd_data = o_pagemask;
            mmu_pkg::SEL_ENTRYLO0: o_cp0_rd_data = o_entrylo0;
            mmu_pkg::SEL_ENTRYLO1: o_cp0_rd_data = o_entrylo1;
            default:               o_cp0_rd_data = '0;
        endcase
    end

endmodule

// File: verilog/mmu_top.sv
module mmu_top #(
    parameter int TLB_ENTRIES = 16,
    localparam int IDX_W = $clog2(TLB_ENTRIES),
    localparam int FLAT_W = TLB_ENTRIES * 32
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [31:0]       i_inst_vaddr,
    input  logic [31:0]       i_data_vaddr,
    input  mmu_pkg::tlb_op_e  i_op,
    input  logic              i_cp0_wr_en,
    input  mmu_pkg::cp0_sel_e i_cp0_sel,
    input  logic [31:0]       i_cp0_wr_data,
    output logic [31:0]       o_cp0_rd_data,
    output logic [31:0]       o_inst_paddr,
    output logic              o_inst_uncached,
    output logic              o_inst_refill,
    output logic              o_inst_invalid,
    output logic [31:0]       o_data_paddr,
    output logic              o_data_uncached,
    output logic              o_data_refill,
    output logic              o_data_invalid,
    output logic              o_data_dirty
);

    logic [IDX_W-1:0]  index;
    logic [31:0]       entryhi;
    logic [31:0]       pagemask;
    logic [31:0]       entrylo0;
    logic [31:0]       entrylo1;
    logic              tlb_we;

    logic [31:0]       rd_entryhi;
    logic [31:0]       rd_pagemask;
    logic [31:0]       rd_entrylo0;
    logic [31:0]       rd_entrylo1;

    logic [FLAT_W-1:0] entryhi_flat;
    logic [FLAT_W-1:0] pagemask_flat;
    logic [FLAT_W-1:0] entrylo0_flat;
    logic [FLAT_W-1:0] entrylo1_flat;

    logic              probe_hit;
    logic [IDX_W-1:0]  probe_index;
    logic              inst_hit;
    logic [31:0]       inst_entrylo;
    logic              data_hit;
    logic [31:0]       data_entrylo;

    cp0_tlb_regs #(.TLB_ENTRIES(TLB_ENTRIES)) regs_i (
        .clk(clk), .rst(rst), .i_op(i_op),
        .i_cp0_wr_en(i_cp0_wr_en), .i_cp0_sel(i_cp0_sel),
        .i_cp0_wr_data(i_cp0_wr_data), .o_cp0_rd_data(o_cp0_rd_data),
        .i_probe_hit(probe_hit), .i_probe_index(probe_index),
        .i_rd_entryhi(rd_entryhi), .i_rd_pagemask(rd_pagemask),
        .i_rd_entrylo0(rd_entrylo0), .i_rd_entrylo1(rd_entrylo1),
        .o_index(index), .o_entryhi(entryhi), .o_pagemask(pagemask),
        .o_entrylo0(entrylo0), .o_entrylo1(entrylo1), .o_tlb_we(tlb_we)
    );

    tlb_entry_array #(.TLB_ENTRIES(TLB_ENTRIES)) array_i (
        .clk(clk), .rst(rst), .i_we(tlb_we), .i_index(index),
        .i_entryhi(entryhi), .i_pagemask(pagemask),
        .i_entrylo0(entrylo0), .i_entrylo1(entrylo1),
        .o_rd_entryhi(rd_entryhi), .o_rd_pagemask(rd_pagemask),
        .o_rd_entrylo0(rd_entrylo0), .o_rd_entrylo1(rd_entrylo1),
        .o_entryhi_flat(entryhi_flat), .o_pagemask_flat(pagemask_flat),
        .o_entrylo0_flat(entrylo0_flat), .o_entrylo1_flat(entrylo1_flat)
    );

    tlb_match #(.TLB_ENTRIES(TLB_ENTRIES)) inst_match_i (
        .i_vaddr(i_inst_vaddr), .i_asid(entryhi[7:0]),
        .i_entryhi_flat(entryhi_flat), .i_pagemask_flat(pagemask_flat),
        .i_entrylo0_flat(entrylo0_flat), .i_entrylo1_flat(entrylo1_flat),
        .o_hit(inst_hit), .o_hit_index(), .o_entrylo(inst_entrylo)
    );

    tlb_match #(.TLB_ENTRIES(TLB_ENTRIES)) data_match_i (
        .i_vaddr(i_data_vaddr), .i_asid(entryhi[7:0]),
        .i_entryhi_flat(entryhi_flat), .i_pagemask_flat(pagemask_flat),
        .i_entrylo0_flat(entrylo0_flat), .i_entrylo1_flat(entrylo1_flat),
        .o_hit(data_hit), .o_hit_index(), .o_entrylo(data_entrylo)
    );

    // probe looks up EntryHi itself
    tlb_match #(.TLB_ENTRIES(TLB_ENTRIES)) probe_match_i (
        .i_vaddr(entryhi), .i_asid(entryhi[7:0]),
        .i_entryhi_flat(entryhi_flat), .i_pagemask_flat(pagemask_flat),
        .i_entrylo0_flat(entrylo0_flat), .i_entrylo1_flat(entrylo1_flat),
        .o_hit(probe_hit), .o_hit_index(probe_index), .o_entrylo()
    );

    addr_translate inst_xlate_i (
        .i_vaddr(i_inst_vaddr), .i_hit(inst_hit), .i_entrylo(inst_entrylo),
        .o_paddr(o_inst_paddr), .o_uncached(o_inst_uncached),
        .o_refill(o_inst_refill), .o_invalid(o_inst_invalid), .o_dirty()
    );

    addr_translate data_xlate_i (
        .i_vaddr(i_data_vaddr), .i_hit(data_hit), .i_entrylo(data_entrylo),
        .o_paddr(o_data_paddr), .o_uncached(o_data_uncached),
        .o_refill(o_data_refill), .o_invalid(o_data_invalid), .o_dirty(o_data_dirty)
    );

endmodule

// File: sim/mmu_ref_model.svh
`ifndef MMU_REF_MODEL_SVH
`define MMU_REF_MODEL_SVH

typedef struct packed
{
    logic [31:0] paddr;
    logic        uncached;
    logic        refill;
    logic        invalid;
    logic        dirty;
} xlate_t;

// shadow TLB, global flag kept apart from the EntryLo values
logic [31:0] sh_hi [16];
logic [31:0] sh_pm [16];
logic [31:0] sh_lo0 [16];
logic [31:0] sh_lo1 [16];
logic        sh_g [16];

// shadow cp0 registers
logic [31:0] sh_index;
logic [31:0] sh_entryhi;
logic [31:0] sh_pagemask;
logic [31:0] sh_entrylo0;
logic [31:0] sh_entrylo1;

logic [31:0] lcg_state = 32'h909e_8f62;

// two lcg steps, upper halves only
function automatic logic [31:0] next_rand();
    logic [31:0] upper;
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    upper = lcg_state & 32'hffff_0000;
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return upper | (lcg_state >> 16);
endfunction

// first matching entry, -1 on a miss
function automatic int find_entry(logic [31:0] va, logic [7:0] asid);
    logic [18:0] care;
    for (int i = 0; i < 16; i++)
    begin
        care = ~sh_pm[i][31:13];
        if ((((va[31:13] ^ sh_hi[i][31:13]) & care) == 19'd0) &&
            (sh_g[i] || sh_hi[i][7:0] == asid))
        begin
            return i;
        end
    end
    return -1;
endfunction

function automatic xlate_t expect_xlate(logic [31:0] va);
    xlate_t      x;
    logic [31:0] lo;
    int          e;
    x = '0;
    // kseg0 and kseg1
    if (va[31:30] == 2'b10)
    begin
        x.paddr    = {3'b000, va[28:0]};
        x.uncached = va[29];
        return x;
    end
    e = find_entry(va, sh_entryhi[7:0]);
    if (e < 0)
    begin
        x.refill = 1'b1;
        return x;
    end
    lo = va[12] ? sh_lo1[e] : sh_lo0[e];
    x.paddr    = {lo[25:6], va[11:0]};
    x.uncached = lo[5:3] == 3'd2;
    x.invalid  = !lo[1];
    x.dirty    = lo[2];
    return x;
endfunction

function automatic logic [31:0] expect_rd(mmu_pkg::cp0_sel_e s);
    case (s)
        mmu_pkg::SEL_INDEX:    return sh_index;
        mmu_pkg::SEL_ENTRYHI:  return sh_entryhi;
        mmu_pkg::SEL_PAGEMASK: return sh_pagemask;
        mmu_pkg::SEL_ENTRYLO0: return sh_entrylo0;
        mmu_pkg::SEL_ENTRYLO1: return sh_entrylo1;
        default:               return 32'd0;
    endcase
endfunction

task automatic clear_model();
    for (int i = 0; i < 16; i++)
    begin
        sh_hi[i]  = '0;
        sh_pm[i]  = '0;
        sh_lo0[i] = '0;
        sh_lo1[i] = '0;
        sh_g[i]   = 1'b0;
    end
    sh_index    = '0;
    sh_entryhi  = '0;
    sh_pagemask = '0;
    sh_entrylo0 = '0;
    sh_entrylo1 = '0;
endtask

`endif

// File: sim/tb_mmu.sv
module tb_mmu;
    timeunit 1ns;
    timeprecision 1ps;

    logic              clk;
    logic              rst;
    logic [31:0]       inst_vaddr;
    logic [31:0]       data_vaddr;
    mmu_pkg::tlb_op_e  op;
    logic              wr_en;
    mmu_pkg::cp0_sel_e sel;
    logic [31:0]       wr_data;
    logic [31:0]       rd_data;
    logic [31:0]       inst_paddr;
    logic              inst_uncached;
    logic              inst_refill;
    logic              inst_invalid;
    logic [31:0]       data_paddr;
    logic              data_uncached;
    logic              data_refill;
    logic              data_invalid;
    logic              data_dirty;

    string test_name = "reset";
    string cur_test = "reset";
    int    checks = 0;
    int    errors = 0;
    int    timeouts = 0;
    logic  stim_done = 1'b0;
    logic  flushed = 1'b0;

    // entries the stimulus has written, for aiming lookups at them
    logic [18:0] vpn_of [16];
    logic [31:0] pm_of [16];
    logic [7:0]  asid_of [16];
    logic        written = 1'b0;

    `include "mmu_ref_model.svh"

    mmu_top #(.TLB_ENTRIES(16)) dut_i (
        .clk(clk), .rst(rst),
        .i_inst_vaddr(inst_vaddr), .i_data_vaddr(data_vaddr), .i_op(op),
        .i_cp0_wr_en(wr_en), .i_cp0_sel(sel), .i_cp0_wr_data(wr_data),
        .o_cp0_rd_data(rd_data),
        .o_inst_paddr(inst_paddr), .o_inst_uncached(inst_uncached),
        .o_inst_refill(inst_refill), .o_inst_invalid(inst_invalid),
        .o_data_paddr(data_paddr), .o_data_uncached(data_uncached),
        .o_data_refill(data_refill), .o_data_invalid(data_invalid),
        .o_data_dirty(data_dirty)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #20 clk = ~clk;
        end
    end

    // register and array effect of one cycle as seen from the next edge
    task automatic apply_cycle(input mmu_pkg::tlb_op_e o, input logic we,
                               input mmu_pkg::cp0_sel_e s, input logic [31:0] d);
        int k;
        int e;
        k = int'(sh_index[3:0]);
        e = find_entry(sh_entryhi, sh_entryhi[7:0]);
        case (o)
            mmu_pkg::OP_TLBWI:
            begin
                sh_hi[k]  = sh_entryhi;
                sh_pm[k]  = sh_pagemask;
                sh_lo0[k] = sh_entrylo0 & ~32'd1;
                sh_lo1[k] = sh_entrylo1 & ~32'd1;
                sh_g[k]   = sh_entrylo0[0] & sh_entrylo1[0];
            end
            mmu_pkg::OP_TLBP:
                sh_index = (e < 0) ? (sh_index | 32'h8000_0000) : 32'(e);
            mmu_pkg::OP_TLBR:
            begin
                sh_entryhi  = sh_hi[k];
                sh_pagemask = sh_pm[k];
                sh_entrylo0 = sh_lo0[k] | 32'(sh_g[k]);
                sh_entrylo1 = sh_lo1[k] | 32'(sh_g[k]);
            end
            default:
            begin
            end
        endcase
        if (we && s == mmu_pkg::SEL_INDEX && o != mmu_pkg::OP_TLBP)
            sh_index = d & 32'h8000_000f;
        if (we && o != mmu_pkg::OP_TLBR)
        begin
            if (s == mmu_pkg::SEL_ENTRYHI)
                sh_entryhi = d & 32'hffff_e0ff;
            if (s == mmu_pkg::SEL_PAGEMASK)
                sh_pagemask = d & 32'h1fff_e000;
            if (s == mmu_pkg::SEL_ENTRYLO0)
                sh_entrylo0 = d & 32'h03ff_ffff;
            if (s == mmu_pkg::SEL_ENTRYLO1)
                sh_entrylo1 = d & 32'h03ff_ffff;
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected)
        else
        begin
            errors++;
            $display("** Error %s: %s expected %h, actual %h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic check_port(input string port, input xlate_t exp, input logic [31:0] paddr,
                              input logic uncached, input logic refill, input logic invalid,
                              input logic dirty, input logic has_dirty);
        check_value({port, " refill"}, 32'(exp.refill), 32'(refill));
        check_value({port, " invalid"}, 32'(exp.invalid), 32'(invalid));
        // a miss leaves paddr and attributes undefined
        if (!exp.refill)
        begin
            check_value({port, " paddr"}, exp.paddr, paddr);
            check_value({port, " uncached"}, 32'(exp.uncached), 32'(uncached));
            if (has_dirty)
                check_value({port, " dirty"}, 32'(exp.dirty), 32'(dirty));
        end
    endtask

    // sample late in each cycle when outputs have settled
    initial
    begin : compare_outputs
        forever
        begin
            @(posedge clk);
            #35;
            if (rst)
            begin
                clear_model();
            end
            else
            begin
                check_value("cp0 read", expect_rd(sel), rd_data);
                check_port("inst", expect_xlate(inst_vaddr), inst_paddr, inst_uncached,
                           inst_refill, inst_invalid, 1'b0, 1'b0);
                check_port("data", expect_xlate(data_vaddr), data_paddr, data_uncached,
                           data_refill, data_invalid, data_dirty, 1'b1);
                apply_cycle(op, wr_en, sel, wr_data);
                if (stim_done)
                    flushed = 1'b1;
            end
        end
    end

    function automatic logic [31:0] pick_vaddr();
        logic [31:0] r;
        logic [31:0] s;
        int          slot;
        r = next_rand();
        s = next_rand();
        if (!written || r[31:30] == 2'b00)
            return s;
        slot = int'(r[3:0]);
        // bits under the page mask are free
        return {vpn_of[slot] ^ (s[31:13] & pm_of[slot][31:13]), s[12:0]};
    endfunction

    task automatic drive(input mmu_pkg::tlb_op_e o, input logic we, input mmu_pkg::cp0_sel_e s,
                         input logic [31:0] d, input logic [31:0] iva, input logic [31:0] dva);
        @(posedge clk);
        op         <= o;
        wr_en      <= we;
        sel        <= s;
        wr_data    <= d;
        inst_vaddr <= iva;
        data_vaddr <= dva;
        test_name  <= cur_test;
    endtask

    task automatic write_reg(input mmu_pkg::cp0_sel_e s, input logic [31:0] d);
        drive(mmu_pkg::OP_NONE, 1'b1, s, d, pick_vaddr(), pick_vaddr());
    endtask

    task automatic run_op(input mmu_pkg::tlb_op_e o);
        drive(o, 1'b0, mmu_pkg::SEL_INDEX, 32'd0, pick_vaddr(), pick_vaddr());
    endtask

    task automatic read_reg(input mmu_pkg::cp0_sel_e s);
        drive(mmu_pkg::OP_NONE, 1'b0, s, 32'd0, pick_vaddr(), pick_vaddr());
    endtask

    task automatic lookups(input int n);
        repeat (n)
        begin
            read_reg(mmu_pkg::cp0_sel_e'(3'(next_rand() % 32'd5)));
        end
    endtask

    function automatic logic [31:0] random_entrylo(input logic g);
        logic [31:0] lo;
        lo = next_rand() & 32'h03ff_fffe;
        if (next_rand() < 32'h4000_0000)
            lo[5:3] = 3'd2;
        return lo | 32'(g);
    endfunction

    // bits 27:24 carry the slot so VPN2 values never overlap
    task automatic write_entry(input int slot, input logic [7:0] asid, input logic glob);
        logic [31:0] r;
        logic [3:0]  top;
        logic [31:0] lo0;
        logic [31:0] lo1;
        r = next_rand();
        top = r[31:28];
        if (top[3:2] == 2'b10)
            top[3] = 1'b0;
        vpn_of[slot] = {top, 4'(slot), r[10:0]};
        case (r[13:11])
            3'd1: pm_of[slot] = 32'h0000_6000;
            3'd2: pm_of[slot] = 32'h0001_e000;
            3'd3: pm_of[slot] = 32'h0007_e000;
            3'd4: pm_of[slot] = 32'h001f_e000;
            default: pm_of[slot] = 32'h0;
        endcase
        asid_of[slot] = asid;
        lo0 = random_entrylo(glob | r[14]);
        lo1 = random_entrylo(glob);
        write_reg(mmu_pkg::SEL_INDEX, 32'(slot));
        write_reg(mmu_pkg::SEL_ENTRYHI, {vpn_of[slot], 5'b0, asid});
        write_reg(mmu_pkg::SEL_PAGEMASK, pm_of[slot]);
        write_reg(mmu_pkg::SEL_ENTRYLO0, lo0);
        write_reg(mmu_pkg::SEL_ENTRYLO1, lo1);
        run_op(mmu_pkg::OP_TLBWI);
    endtask

    initial
    begin : stimulus
        logic [31:0] old_va;
        logic [7:0]  asid;
        int          waited;
        rst        = 1'b1;
        op         = mmu_pkg::OP_NONE;
        wr_en      = 1'b0;
        sel        = mmu_pkg::SEL_INDEX;
        wr_data    = 32'd0;
        inst_vaddr = 32'd0;
        data_vaddr = 32'd0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        cur_test = "after reset";
        for (int s = 0; s < 5; s++)
            read_reg(mmu_pkg::cp0_sel_e'(3'(s)));
        lookups(24);
        drive(mmu_pkg::OP_NONE, 1'b0, mmu_pkg::SEL_ENTRYLO1, 32'd0,
              32'h8012_3456, 32'ha7fe_dcba);

        cur_test = "tlbwi fill";
        for (int i = 0; i < 16; i++)
        begin
            asid = (next_rand() < 32'hb000_0000) ? 8'h5a : (8'(next_rand()) | 8'h80);
            write_entry(i, asid, i % 4 == 1);
        end
        written = 1'b1;
        write_reg(mmu_pkg::SEL_ENTRYHI, 32'h0000_005a);
        cur_test = "random lookups";
        lookups(200);

        cur_test = "asid change";
        write_reg(mmu_pkg::SEL_ENTRYHI, 32'h0000_003c);
        lookups(100);

        cur_test = "tlbr";
        for (int i = 0; i < 16; i += 3)
        begin
            write_reg(mmu_pkg::SEL_INDEX, 32'(i));
            run_op(mmu_pkg::OP_TLBR);
            for (int s = 1; s < 5; s++)
                read_reg(mmu_pkg::cp0_sel_e'(3'(s)));
        end

        cur_test = "tlbp hit";
        for (int i = 2; i < 16; i += 5)
        begin
            write_reg(mmu_pkg::SEL_ENTRYHI, {vpn_of[i], 5'b0, asid_of[i]});
            run_op(mmu_pkg::OP_TLBP);
            read_reg(mmu_pkg::SEL_INDEX);
        end
        cur_test = "tlbp miss";
        write_reg(mmu_pkg::SEL_INDEX, 32'd9);
        // flip va bit 28 which lies outside every page mask
        write_reg(mmu_pkg::SEL_ENTRYHI, {vpn_of[4] ^ 19'h08000, 13'h005a});
        run_op(mmu_pkg::OP_TLBP);
        read_reg(mmu_pkg::SEL_INDEX);

        cur_test = "tlbwi replace";
        write_reg(mmu_pkg::SEL_ENTRYHI, 32'h0000_005a);
        old_va = {vpn_of[3], 13'h0123};
        write_entry(3, 8'h5a, 1'b0);
        drive(mmu_pkg::OP_NONE, 1'b0, mmu_pkg::SEL_ENTRYLO1, 32'd0,
              old_va, {vpn_of[3], 13'h1abc});
        lookups(50);
        stim_done = 1'b1;

        waited = 0;
        while (!flushed && waited < 10)
        begin
            @(posedge clk);
            waited++;
        end
        if (!flushed)
        begin
            timeouts++;
            $display("timed out waiting for the compare process to check the last cycle");
        end
        $display("checks %0d, value errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0 && checks > 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: sim.f
+incdir+sim
verilog/mmu_pkg.sv
verilog/addr_translate.sv
verilog/tlb_match.sv
verilog/tlb_entry_array.sv
verilog/cp0_tlb_regs.sv
verilog/mmu_top.sv
sim/tb_mmu.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sim.f --top-module tb_mmu
out=$(./obj_dir/Vtb_mmu)
echo "$out"
if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1
